/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_dma_distrib
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dma_burst_splitter.sv */
/*
  Cuts a burst at region boundaries. A new burst is taken only once the last
  chunk of the previous one has gone out.
*/
module dma_burst_splitter import dma_pkg::*; #(
  parameter int unsigned NumGroups  = num_groups,
  parameter int unsigned SliceBytes = slice_bytes
) (
  input  logic clk_i,
  input  logic reset_i,
  dma_req_if.sink   burst_i,
  dma_req_if.source chunk_o,
  output logic busy_o
);

  localparam int unsigned RegionBytes = NumGroups * SliceBytes;
  localparam int unsigned RegionBits  = $clog2(RegionBytes);

  dma_req_t             rem_q;
  logic                 busy_q;
  logic [len_width-1:0] to_boundary;
  logic [len_width-1:0] chunk_len;
  logic                 last;

  // Bytes left before the next region starts
  assign to_boundary = len_width'(RegionBytes) - len_width'(rem_q.dst[RegionBits-1:0]);
  assign chunk_len   = (rem_q.len < to_boundary) ? rem_q.len : to_boundary;
  assign last        = (rem_q.len == chunk_len);

  assign burst_i.ready = ~busy_q;
  assign chunk_o.valid = busy_q;
  assign chunk_o.req   = '{src: rem_q.src, dst: rem_q.dst, len: chunk_len};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (burst_i.valid && burst_i.ready) begin
      busy_q <= 1'b1;
    end else if (chunk_o.ready && busy_q && last) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (burst_i.valid && burst_i.ready) begin
      rem_q <= burst_i.req;
    end else if (chunk_o.ready && busy_q) begin
      rem_q.src <= rem_q.src + addr_width'(chunk_len);
      rem_q.dst <= rem_q.dst + addr_width'(chunk_len);
      rem_q.len <= rem_q.len - chunk_len;
    end
  end

  assign busy_o = busy_q;

endmodule

/* dma_completion_tracker.sv */
/*
  At most NumGroups * FifoDepth pieces may wait for their done pulse.
  A done pulse must never come before its piece was issued.
*/
module dma_completion_tracker import dma_pkg::*; #(
  parameter int unsigned NumGroups = num_groups,
  parameter int unsigned FifoDepth = fifo_depth
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [NumGroups-1:0] issued_i,
  input  logic [NumGroups-1:0] done_i,
  input  logic [2:0]           stage_busy_i,
  output logic                 idle_o
);

  localparam int unsigned CntWidth = $clog2(NumGroups * FifoDepth + 1);
  localparam int unsigned NumWidth = $clog2(NumGroups + 1);

  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic [NumWidth-1:0] n_issued;
  logic [NumWidth-1:0] n_done;
  logic                idle_q;

  always_comb begin
    n_issued = '0;
    n_done   = '0;
    for (int g = 0; g < NumGroups; g++) begin
      n_issued = n_issued + NumWidth'(issued_i[g]);
      n_done   = n_done + NumWidth'(done_i[g]);
    end
    cnt_d = cnt_q + CntWidth'(n_issued) - CntWidth'(n_done);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      idle_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_d;
      idle_q <= (cnt_q == '0) && !(|stage_busy_i);
    end
  end

  assign idle_o = idle_q;

endmodule

/* dma_distrib_top.sv */
/*
  DMA front end: ingress cut, region split, per-group distribution and buffers.
  Pieces count as issued when a group buffer takes them, until grp_done_i.
*/
module dma_distrib_top import dma_pkg::*; #(
  parameter int unsigned NumGroups  = num_groups,
  parameter int unsigned SliceBytes = slice_bytes,
  parameter int unsigned FifoDepth  = fifo_depth
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  dma_req_t                       dma_req_i,
  input  logic                           dma_req_valid_i,
  output logic                           dma_req_ready_o,
  output dma_req_t       [NumGroups-1:0] grp_req_o,
  output logic           [NumGroups-1:0] grp_valid_o,
  input  logic           [NumGroups-1:0] grp_ready_i,
  input  logic           [NumGroups-1:0] grp_done_i,
  output logic                           idle_o
);

  logic [NumGroups-1:0] issued;
  logic [2:0]           stage_busy;

  dma_req_if in_if ();
  dma_req_if cut_if ();
  dma_req_if chunk_if ();
  dma_req_if piece_if [NumGroups] ();
  dma_req_if grp_if [NumGroups] ();

  assign in_if.valid     = dma_req_valid_i;
  assign in_if.req       = dma_req_i;
  assign dma_req_ready_o = in_if.ready;

  dma_spill_buffer i_ingress_buffer (
    .clk_i  (clk_i        ),
    .reset_i(reset_i      ),
    .in_i   (in_if        ),
    .out_o  (cut_if       ),
    .busy_o (stage_busy[0])
  );

  dma_burst_splitter #(
    .NumGroups (NumGroups ),
    .SliceBytes(SliceBytes)
  ) i_splitter (
    .clk_i  (clk_i        ),
    .reset_i(reset_i      ),
    .burst_i(cut_if       ),
    .chunk_o(chunk_if     ),
    .busy_o (stage_busy[1])
  );

  dma_group_distributor #(
    .NumGroups (NumGroups ),
    .SliceBytes(SliceBytes)
  ) i_distributor (
    .clk_i  (clk_i        ),
    .reset_i(reset_i      ),
    .chunk_i(chunk_if     ),
    .piece_o(piece_if     ),
    .busy_o (stage_busy[2])
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group
    dma_spill_buffer i_group_buffer (
      .clk_i  (clk_i      ),
      .reset_i(reset_i    ),
      .in_i   (piece_if[g]),
      .out_o  (grp_if[g]  ),
      .busy_o (           )
    );

    // Counted on entry to the group buffer
    assign issued[g]      = piece_if[g].valid & piece_if[g].ready;
    assign grp_req_o[g]   = grp_if[g].req;
    assign grp_valid_o[g] = grp_if[g].valid;
    assign grp_if[g].ready = grp_ready_i[g];
  end

  dma_completion_tracker #(
    .NumGroups(NumGroups),
    .FifoDepth(FifoDepth)
  ) i_tracker (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .issued_i    (issued    ),
    .done_i      (grp_done_i),
    .stage_busy_i(stage_busy),
    .idle_o      (idle_o    )
  );

endmodule

/* dma_group_distributor.sv */
/*
  Expects chunks that stay inside one region. Each group whose slice the chunk
  touches gets one piece, and all pieces are offered in the same cycle.
*/
module dma_group_distributor import dma_pkg::*; #(
  parameter int unsigned NumGroups  = num_groups,
  parameter int unsigned SliceBytes = slice_bytes
) (
  input  logic clk_i,
  input  logic reset_i,
  dma_req_if.sink   chunk_i,
  dma_req_if.source piece_o [NumGroups],
  output logic busy_o
);

  localparam int unsigned RegionBytes = NumGroups * SliceBytes;
  localparam int unsigned RegionBits  = $clog2(RegionBytes);

  dma_req_t              chunk_q;
  logic                  busy_q;
  logic [NumGroups-1:0]  acc_mask_q;
  logic [NumGroups-1:0]  involved;
  logic [NumGroups-1:0]  fire;
  logic                  all_done;
  logic [len_width-1:0]  off;
  logic [len_width-1:0]  end_off;
  logic [addr_width-1:0] region_base;

  // Chunk span as offsets within its region
  assign off         = len_width'(chunk_q.dst[RegionBits-1:0]);
  assign end_off     = off + chunk_q.len;
  assign region_base = {chunk_q.dst[addr_width-1:RegionBits], {RegionBits{1'b0}}};

  for (genvar g = 0; g < NumGroups; g++) begin : gen_piece
    localparam logic [len_width-1:0] SliceLo = len_width'(g * SliceBytes);
    localparam logic [len_width-1:0] SliceHi = len_width'((g + 1) * SliceBytes);

    logic [len_width-1:0] p_lo;
    logic [len_width-1:0] p_hi;
    dma_req_t             piece;

    // Overlap of the chunk with this group's slice
    assign p_lo        = (off > SliceLo) ? off : SliceLo;
    assign p_hi        = (end_off < SliceHi) ? end_off : SliceHi;
    assign involved[g] = (p_lo < p_hi);

    assign piece.src = chunk_q.src + addr_width'(p_lo - off);
    assign piece.dst = region_base + addr_width'(p_lo);
    assign piece.len = p_hi - p_lo;

    assign piece_o[g].req   = piece;
    assign piece_o[g].valid = busy_q & involved[g] & ~acc_mask_q[g];
    assign fire[g]          = busy_q & involved[g] & ~acc_mask_q[g] & piece_o[g].ready;
  end

  // Done once every involved group has taken its piece
  assign all_done      = busy_q & (&(acc_mask_q | fire | ~involved));
  assign chunk_i.ready = ~busy_q | all_done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      acc_mask_q <= '0;
    end else if (chunk_i.valid && chunk_i.ready) begin
      busy_q     <= 1'b1;
      acc_mask_q <= '0;
    end else if (all_done) begin
      busy_q     <= 1'b0;
      acc_mask_q <= '0;
    end else begin
      acc_mask_q <= acc_mask_q | fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (chunk_i.valid && chunk_i.ready) begin
      chunk_q <= chunk_i.req;
    end
  end

  assign busy_o = busy_q;

endmodule

/* dma_pkg.sv */
/*
  TCDM starts at address 0 and is interleaved slice by slice across the groups.
  Slice and region sizes are powers of two, and a region fits in len_width bits.
*/
package dma_pkg;

  localparam int unsigned addr_width = 32;
  localparam int unsigned len_width = 16;

  // Slice geometry, 16 banks of 4 bytes per group
  localparam int unsigned num_groups = 4;
  localparam int unsigned slice_bytes = 64;
  localparam int unsigned region_bytes = num_groups * slice_bytes;

  // Pieces a group may hold before reporting done
  localparam int unsigned fifo_depth = 16;

  typedef logic [$clog2(num_groups)-1:0] group_idx_t;

  // Byte length is at least 1
  typedef struct packed {
    logic [addr_width-1:0] src;
    logic [addr_width-1:0] dst;
    logic [len_width-1:0]  len;
  } dma_req_t;

endpackage

/* dma_req_if.sv */
/*
  Valid/ready request channel. Valid and req stay stable until ready is seen.
*/
interface dma_req_if import dma_pkg::*; ();

  logic     valid;
  logic     ready;
  dma_req_t req;

  modport source (
    output valid,
    output req,
    input  ready
  );

  modport sink (
    input  valid,
    input  req,
    output ready
  );

endinterface

/* dma_spill_buffer.sv */
/*
  Two-entry spill register. Output is one cycle behind the input and
  ready only drops once both entries are held.
*/
module dma_spill_buffer import dma_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  dma_req_if.sink   in_i,
  dma_req_if.source out_o,
  output logic busy_o
);

  dma_req_t a_data_q;
  dma_req_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign a_fill  = in_i.valid & in_i.ready;
  // Entry a empties whenever b is free
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~out_o.ready;
  assign b_drain = b_full_q & out_o.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_i.req;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  assign in_i.ready  = ~a_full_q | ~b_full_q;
  assign out_o.valid = a_full_q | b_full_q;
  // b holds the older entry, so it goes first
  assign out_o.req   = b_full_q ? b_data_q : a_data_q;
  assign busy_o      = a_full_q | b_full_q;

endmodule

/* tb_dma_distrib.sv */
/*
  Group sinks take pieces under random back-pressure and pulse done 1 to 8
  cycles later. Destinations stay inside a 64 KiB TCDM starting at 0.
*/
module tb_dma_distrib import dma_pkg::*; ();

  localparam int unsigned num_random = 200;
  localparam int unsigned num_reqs   = num_random + 3;

  logic                            clk_i = 1'b0;
  logic                            reset_i;
  dma_req_t                        dma_req_i;
  logic                            dma_req_valid_i;
  logic                            dma_req_ready_o;
  dma_req_t       [num_groups-1:0] grp_req_o;
  logic           [num_groups-1:0] grp_valid_o;
  logic           [num_groups-1:0] grp_ready_i = '0;
  logic           [num_groups-1:0] grp_done_i = '0;
  logic                            idle_o;

  logic [31:0] rand_state = 32'hbaf0;
  int unsigned cyc = 0;

  // Expected pieces and done due cycles, one queue per group
  dma_req_t    exp_q [num_groups][$];
  int unsigned due_q [num_groups][$];

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  dma_distrib_top #(
    .NumGroups (num_groups ),
    .SliceBytes(slice_bytes),
    .FifoDepth (fifo_depth )
  ) UUT (
    .clk_i          (clk_i          ),
    .reset_i        (reset_i        ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_o(dma_req_ready_o),
    .grp_req_o      (grp_req_o      ),
    .grp_valid_o    (grp_valid_o    ),
    .grp_ready_i    (grp_ready_i    ),
    .grp_done_i     (grp_done_i     ),
    .idle_o         (idle_o         )
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Walk the burst slice by slice, each slice belongs to one group
  function automatic void expected_pieces(input dma_req_t req);
    int unsigned addr;
    int unsigned left;
    int unsigned n;
    int unsigned slice_end;
    logic [addr_width-1:0] s;
    dma_req_t piece;
    addr = req.dst;
    s    = req.src;
    left = req.len;
    while (left > 0) begin
      slice_end = (addr / slice_bytes + 1) * slice_bytes;
      n = (left < slice_end - addr) ? left : slice_end - addr;
      piece.src = s;
      piece.dst = addr;
      piece.len = len_width'(n);
      exp_q[(addr / slice_bytes) % num_groups].push_back(piece);
      addr = addr + n;
      s    = s + n;
      left = left - n;
    end
  endfunction

  function automatic int unsigned pending_count();
    int unsigned n;
    n = 0;
    for (int g = 0; g < num_groups; g++) begin
      n = n + exp_q[g].size() + due_q[g].size();
    end
    return n;
  endfunction

  // Group sinks: random ready, one done pulse per accepted piece
  always @(posedge clk_i) begin
    logic [31:0] r;
    #1;
    r = next_rand();
    for (int g = 0; g < num_groups; g++) begin
      grp_ready_i[g] = (r[2*g +: 2] != 2'b00);
      if (due_q[g].size() > 0 && due_q[g][0] <= cyc) begin
        grp_done_i[g] = 1'b1;
        void'(due_q[g].pop_front());
      end else begin
        grp_done_i[g] = 1'b0;
      end
    end
  end

  // Compare at the falling edge, where outputs and inputs are stable
  always @(negedge clk_i) begin
    dma_req_t    want;
    int unsigned delay;
    if (!reset_i) begin
      for (int g = 0; g < num_groups; g++) begin
        if (grp_valid_o[g] && grp_ready_i[g]) begin
          assert (exp_q[g].size() > 0)
            else abort_run($sformatf("group %0d got a piece no request produced", g));
          want = exp_q[g].pop_front();
          assert (grp_req_o[g] == want)
            else abort_run($sformatf("error: grp_req_o[%0d] expected %h got %h",
                                     g, want, grp_req_o[g]));
          delay = next_rand() % 8 + 1;
          due_q[g].push_back(cyc + delay);
        end
        if (due_q[g].size() > 0) begin
          assert (!idle_o)
            else abort_run("idle_o was high while a piece still waited for its done pulse");
        end
      end
    end
  end

  task automatic send_req(input dma_req_t req);
    expected_pieces(req);
    dma_req_i       = req;
    dma_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!dma_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    dma_req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (pending_count() > 0) @(negedge clk_i);
    while (!idle_o && n < 8) begin
      n++;
      @(negedge clk_i);
    end
    assert (idle_o) else abort_run("idle_o did not return high after the last done pulse");
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    dma_req_t req;
    dma_req_t rand_req [num_random];
    reset_i         = 1'b1;
    dma_req_i       = '0;
    dma_req_valid_i = 1'b0;
    // Random bursts, dst kept inside a 64 KiB TCDM
    for (int i = 0; i < num_random; i++) begin
      rand_req[i].len = len_width'(next_rand() % 600 + 1);
      rand_req[i].dst = next_rand() % 32'd64936;
      rand_req[i].src = next_rand();
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    assert (grp_valid_o == '0)
      else abort_run($sformatf("error: grp_valid_o expected 0 got %h", grp_valid_o));
    assert (dma_req_ready_o)
      else abort_run($sformatf("error: dma_req_ready_o expected 1 got %h", dma_req_ready_o));
    assert (idle_o) else abort_run($sformatf("error: idle_o expected 1 got %h", idle_o));
    @(posedge clk_i);
    #1;
    // Inside one slice of group 1
    req = '{src: 32'h0001_0000, dst: 32'h0000_0148, len: 16'd16};
    send_req(req);
    wait_idle();
    // Groups 0 to 2 of one region
    req = '{src: 32'h0002_0004, dst: 32'h0000_0230, len: 16'd100};
    send_req(req);
    wait_idle();
    // Crosses three region boundaries
    req = '{src: 32'h0003_0001, dst: 32'h0000_03f0, len: 16'd600};
    send_req(req);
    wait_idle();
    for (int i = 0; i < num_random; i++) begin
      send_req(rand_req[i]);
    end
    wait_idle();
    assert (grp_valid_o == '0)
      else abort_run($sformatf("error: grp_valid_o expected 0 got %h", grp_valid_o));
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(num_reqs * 2000);
    abort_run($sformatf("timeout: the run did not finish within %0d time units",
                        num_reqs * 2000));
  end

endmodule

/* vlog.f */
dma_pkg.sv
dma_req_if.sv
dma_spill_buffer.sv
dma_burst_splitter.sv
dma_group_distributor.sv
dma_completion_tracker.sv
dma_distrib_top.sv
tb_dma_distrib.sv
